// ==== all.f ====
design/mul_pkg.sv
design/mul_pipe_reg.sv
design/mul_decode.sv
design/mul_execute.sv
design/mul_result.sv
design/mul_unit.sv
bench/mul_unit_props.sv
bench/mul_unit_tb.sv

// ==== bench/mul_unit_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_props
   import mul_pkg::*;
(
   input logic clk,
   input logic reset,
   input logic go,
   input logic complete
);

   // held reset and the cycle after it
   a_reset_quiet: assert property (
      @(posedge clk) reset |=> !complete [*2]
   )
   else $error("complete high during or just after reset");

   // fixed latency, no back-pressure
   a_go_completes: assert property (
      @(posedge clk) disable iff (reset)
      go |-> ##UNIT_LAT complete
   )
   else $error("go not followed by complete after the unit latency");

   a_no_stray_complete: assert property (
      @(posedge clk) disable iff (reset)
      complete |-> $past(go, UNIT_LAT)
   )
   else $error("complete without a go one unit latency earlier");

endmodule

`default_nettype wire

// ==== bench/mul_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb
   import mul_pkg::*;
();

   logic                      clk = 1'b0;
   logic                      reset;
   logic                      go;
   mul_op_e                   op;
   logic [31:0]               src_a;
   logic [31:0]               src_b;
   logic [LG_ROB_ENTRIES-1:0] rob_ptr_in;
   logic [LG_PRF_ENTRIES-1:0] prf_ptr_in;
   logic                      has_dest;
   logic                      complete;
   mul_wb_t                   wb;

   mul_wb_t     exp_q [$];
   int unsigned edge_q [$];   // edge that sampled go, per operation
   int unsigned edge_cnt = 0;
   logic [15:0] lfsr_state = 16'd2164;

   mul_unit uut (
      .clk        (clk),
      .reset      (reset),
      .go         (go),
      .op         (op),
      .src_a      (src_a),
      .src_b      (src_b),
      .rob_ptr_in (rob_ptr_in),
      .prf_ptr_in (prf_ptr_in),
      .has_dest   (has_dest),
      .complete   (complete),
      .wb         (wb)
   );

   bind mul_unit mul_unit_props u_props (
      .clk      (clk),
      .reset    (reset),
      .go       (go),
      .complete (complete)
   );

   initial
   begin
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      edge_cnt <= edge_cnt + 1;
   end

   // x^16 + x^15 + x^13 + x^4 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic mul_wb_t expect_wb(input mul_op_e o, input logic [31:0] a,
                                         input logic [31:0] b,
                                         input logic [LG_ROB_ENTRIES-1:0] rob,
                                         input logic [LG_PRF_ENTRIES-1:0] prf,
                                         input logic dest);
      mul_wb_t            r;
      logic signed [63:0] sprod;
      logic [63:0]        uprod;
      sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      uprod = {32'd0, a} * {32'd0, b};
      r.rob_ptr = rob;
      r.prf_ptr = prf;
      r.prf_val = 1'b1;
      if (!dest || prf == '0)
         r.prf_val = 1'b0; // p0 never written
      case (o)
         op_mulh:  r.data = sprod[63:32];
         op_mulhu: r.data = uprod[63:32];
         default:  r.data = uprod[31:0];  // mul and unknown codes
      endcase
      return r;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want)
      begin
         $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
         stop_with_failure("wrong value on the writeback port");
      end
   endtask

   task automatic issue_op(input mul_op_e o, input logic [31:0] a, input logic [31:0] b,
                           input logic [LG_ROB_ENTRIES-1:0] rob,
                           input logic [LG_PRF_ENTRIES-1:0] prf, input logic dest);
      @(posedge clk);
      go <= 1'b1;
      op <= o;
      src_a <= a;
      src_b <= b;
      rob_ptr_in <= rob;
      prf_ptr_in <= prf;
      has_dest <= dest;
      exp_q.push_back(expect_wb(o, a, b, rob, prf, dest));
      edge_q.push_back(edge_cnt + 2); // counter lags this edge, go sampled on the next
   endtask

   task automatic issue_random();
      logic [1:0]                code;
      logic [31:0]               a;
      logic [31:0]               b;
      logic [LG_ROB_ENTRIES-1:0] rob;
      logic [LG_PRF_ENTRIES-1:0] prf;
      logic                      dest;
      code = 2'(take_bits(2));
      a = take_bits(32);
      b = take_bits(32);
      rob = LG_ROB_ENTRIES'(take_bits(LG_ROB_ENTRIES));
      prf = LG_PRF_ENTRIES'(take_bits(LG_PRF_ENTRIES));
      dest = take_bits(1) != 0;
      issue_op(mul_op_e'(code), a, b, rob, prf, dest);
   endtask

   task automatic idle_slot();
      @(posedge clk);
      go <= 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 4 * UNIT_LAT)
      begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0)
         stop_with_failure("timeout: no completion arrived for an issued operation");
   endtask

   task automatic reset_in_stream();
      @(posedge clk);
      go <= 1'b0;
      reset <= 1'b1;
      @(posedge clk);
      // last legal completion was checked at the negedge before
      exp_q.delete();
      edge_q.delete();
      @(posedge clk);
      reset <= 1'b0;
   endtask

   always @(negedge clk)
   begin : compare
      mul_wb_t     want;
      int unsigned go_edge;
      if ($isunknown(complete))
      begin
         stop_with_failure("complete is unknown after reset");
      end
      else if (complete)
      begin
         if (exp_q.size() == 0)
         begin
            stop_with_failure("complete seen with no operation in flight");
         end
         else
         begin
            want = exp_q.pop_front();
            go_edge = edge_q.pop_front();
            // complete is sampled on the next rising edge
            check_equal("completion edge", edge_cnt + 1, go_edge + UNIT_LAT);
            check_equal("rob_ptr", wb.rob_ptr, want.rob_ptr);
            check_equal("prf_ptr", wb.prf_ptr, want.prf_ptr);
            check_equal("prf_val", wb.prf_val, want.prf_val);
            check_equal("data", wb.data, want.data);
         end
      end
   end

   initial
   begin
      logic [31:0] edge_vals [0:4];
      mul_op_e     edge_ops [0:2];
      int          gap;
      go = 1'b0;
      reset = 1'b1;
      op = op_mul;
      src_a = '0;
      src_b = '0;
      rob_ptr_in = '0;
      prf_ptr_in = '0;
      has_dest = 1'b0;
      edge_vals[0] = 32'h0000_0000;
      edge_vals[1] = 32'h0000_0001;
      edge_vals[2] = 32'hffff_ffff;
      edge_vals[3] = 32'h8000_0000;
      edge_vals[4] = 32'h7fff_ffff;
      edge_ops[0] = op_mul;
      edge_ops[1] = op_mulh;
      edge_ops[2] = op_mulhu;
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      // edge operands, every pairing and op
      for (int i = 0; i < 5; i++)
         for (int j = 0; j < 5; j++)
            for (int k = 0; k < 3; k++)
               issue_op(edge_ops[k], edge_vals[i], edge_vals[j],
                        LG_ROB_ENTRIES'(take_bits(LG_ROB_ENTRIES)),
                        LG_PRF_ENTRIES'(take_bits(LG_PRF_ENTRIES)), 1'b1);
      idle_slot();
      drain();

      // destination valid rules
      issue_op(op_mul, 32'd3, 32'd5, 5'd1, 6'd0, 1'b1);
      issue_op(op_mul, 32'd3, 32'd5, 5'd2, 6'd7, 1'b0);
      issue_op(op_mul, 32'd3, 32'd5, 5'd3, 6'd7, 1'b1);
      issue_op(op_mul, 32'd3, 32'd5, 5'd4, 6'd0, 1'b0);
      idle_slot();
      drain();

      for (int n = 0; n < 200; n++)
         issue_random();
      idle_slot();
      drain();

      for (int n = 0; n < 100; n++)
      begin
         issue_random();
         gap = take_bits(3);
         repeat (gap) idle_slot();
      end
      idle_slot();
      drain();

      // flush by reset mid-stream, then stray completes would hit the monitor
      for (int n = 0; n < 20; n++)
         issue_random();
      reset_in_stream();
      repeat (2 * UNIT_LAT) idle_slot();
      for (int n = 0; n < 10; n++)
         issue_random();
      idle_slot();
      drain();

      if (exp_q.size() == 0)
      begin
         $display("Everything OK");
         $finish;
      end
      else
      begin
         stop_with_failure("operations left without a completion");
      end
   end

endmodule

`default_nettype wire

// ==== design/mul_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_decode
   import mul_pkg::*;
(
   input  logic                      go,
   input  mul_op_e                   op,
   input  logic [31:0]               src_a,
   input  logic [31:0]               src_b,
   input  logic [LG_ROB_ENTRIES-1:0] rob_ptr_in,
   input  logic [LG_PRF_ENTRIES-1:0] prf_ptr_in,
   input  logic                      has_dest,
   output logic                      req_valid,
   output mul_req_t                  req
);

   assign req_valid = go;

   always_comb
   begin
      req.src_a = src_a;
      req.src_b = src_b;
      req.is_signed = 1'b0;
      req.tag.high = 1'b0;
      case (op)
         op_mulh:
         begin
            req.is_signed = 1'b1;
            req.tag.high = 1'b1;
         end
         op_mulhu:
         begin
            req.tag.high = 1'b1;
         end
         default:
         begin
            req.tag.high = 1'b0; // op_mul and unknown codes
         end
      endcase
      req.tag.rob_ptr = rob_ptr_in;
      req.tag.prf_ptr = prf_ptr_in;
      // p0 is hardwired, never written
      req.tag.prf_val = has_dest && (prf_ptr_in != '0);
   end

endmodule

`default_nettype wire

// ==== design/mul_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_execute
   import mul_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        req_valid,
   input  mul_req_t    req,
   output logic        res_valid,
   output logic [63:0] product,
   output mul_tag_t    res_tag
);

   logic [31:0] op_a;
   logic [31:0] op_b;
   logic        op_signed;
   logic [63:0] pp [0:31];
   logic [63:0] pp_d1 [14:31]; // rows for groups 2 and 3
   logic [63:0] pp_d2 [25:31];

   mul_pair_t grp1, grp2, grp3;
   mul_pair_t s2_pair, s3_pair;
   logic      s2_pair_v, s3_pair_v;

   logic [MUL_LAT:0] stage_v;
   logic [MUL_LAT:1] tag_v;
   mul_tag_t         tag_d [0:MUL_LAT];

   // one carry-save row
   function automatic mul_pair_t csa_row(input mul_pair_t acc, input logic [63:0] row);
      mul_pair_t   r;
      logic [63:0] maj;
      maj = (acc.sum & acc.carry) | (acc.sum & row) | (acc.carry & row);
      r.sum = acc.sum ^ acc.carry ^ row;
      r.carry = {maj[62:0], 1'b0};
      return r;
   endfunction

   // stage 1
   always_ff @(posedge clk)
   begin
      op_a <= req.src_a;
      op_b <= req.src_b;
      op_signed <= req.is_signed;
   end

   // baugh-wooley partial products
   always_comb
   begin
      logic [63:0] row;
      for (int i = 0; i < 32; i++)
      begin
         row = {32'd0, op_a & {32{op_b[i]}}};
         if (op_signed)
         begin
            if (i == 31)
               row[30:0] = ~row[30:0]; // a[j]*b[31], j < 31
            else
               row[31] = ~row[31];     // a[31]*b[i]
         end
         pp[i] = row << i;
      end
      if (op_signed)
      begin
         pp[0][32] = 1'b1;  // correction ones
         pp[31][63] = 1'b1;
      end
   end

   always_comb
   begin
      grp1 = '{sum: pp[0], carry: pp[1]};
      for (int i = 2; i < 14; i++)
      begin
         grp1 = csa_row(grp1, pp[i]);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 14; i < 32; i++)
      begin
         pp_d1[i] <= pp[i];
      end
      for (int i = 25; i < 32; i++)
      begin
         pp_d2[i] <= pp_d1[i];
      end
   end

   // stage 2
   mul_pipe_reg #(.T(mul_pair_t)) u_pair2 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (stage_v[1]),
      .in_data   (grp1),
      .out_valid (s2_pair_v),
      .out_data  (s2_pair)
   );

   always_comb
   begin
      grp2 = s2_pair;
      for (int i = 14; i < 25; i++)
      begin
         grp2 = csa_row(grp2, pp_d1[i]);
      end
   end

   // stage 3
   mul_pipe_reg #(.T(mul_pair_t)) u_pair3 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (stage_v[2]),
      .in_data   (grp2),
      .out_valid (s3_pair_v),
      .out_data  (s3_pair)
   );

   always_comb
   begin
      grp3 = s3_pair;
      for (int i = 25; i < 32; i++)
      begin
         grp3 = csa_row(grp3, pp_d2[i]);
      end
   end

   // stage 4, carry-propagate add
   always_ff @(posedge clk)
   begin
      product <= grp3.sum + grp3.carry;
   end

   assign tag_d[0] = req.tag;
   assign stage_v[0] = req_valid;
   assign stage_v[1] = tag_v[1];
   assign stage_v[2] = tag_v[2] & s2_pair_v; // both copies of the same valid
   assign stage_v[3] = tag_v[3] & s3_pair_v;
   assign stage_v[4] = tag_v[4];

   for (genvar k = 1; k <= MUL_LAT; k++)
   begin : g_tag
      mul_pipe_reg #(.T(mul_tag_t)) u_tag (
         .clk       (clk),
         .reset     (reset),
         .in_valid  (stage_v[k-1]),
         .in_data   (tag_d[k-1]),
         .out_valid (tag_v[k]),
         .out_data  (tag_d[k])
      );
   end

   assign res_valid = stage_v[MUL_LAT];
   assign res_tag = tag_d[MUL_LAT];

endmodule

`default_nettype wire

// ==== design/mul_pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_pipe_reg
#(
   parameter type T = logic
)
(
   input  logic clk,
   input  logic reset,
   input  logic in_valid,
   input  T     in_data,
   output logic out_valid,
   output T     out_data
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      out_data <= in_data; // loads every cycle
   end

endmodule

`default_nettype wire

// ==== design/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

   localparam int LG_ROB_ENTRIES = 5;
   localparam int LG_PRF_ENTRIES = 6;
   localparam int MUL_LAT = 4;            // register stages inside execute
   localparam int UNIT_LAT = MUL_LAT + 1; // plus the result register

   typedef enum logic [1:0] {
      op_mul   = 2'd0, // low word
      op_mulh  = 2'd1, // signed high word
      op_mulhu = 2'd2  // unsigned high word
   } mul_op_e;

   // travels beside the data through execute
   typedef struct packed {
      logic [LG_ROB_ENTRIES-1:0] rob_ptr;
      logic [LG_PRF_ENTRIES-1:0] prf_ptr;
      logic                      prf_val;
      logic                      high;
   } mul_tag_t;

   typedef struct packed {
      logic [31:0] src_a;
      logic [31:0] src_b;
      logic        is_signed;
      mul_tag_t    tag;
   } mul_req_t;

   // carry already shifted into its column
   typedef struct packed {
      logic [63:0] sum;
      logic [63:0] carry;
   } mul_pair_t;

   typedef struct packed {
      logic [LG_ROB_ENTRIES-1:0] rob_ptr;
      logic [LG_PRF_ENTRIES-1:0] prf_ptr;
      logic                      prf_val;
      logic [31:0]               data;
   } mul_wb_t;

endpackage

`default_nettype wire

// ==== design/mul_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_result
   import mul_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        res_valid,
   input  logic [63:0] product,
   input  mul_tag_t    res_tag,
   output logic        complete,
   output mul_wb_t     wb
);

   logic [31:0] word;

   assign word = res_tag.high ? product[63:32] : product[31:0];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         complete <= 1'b0;
      end
      else
      begin
         complete <= res_valid;
      end
   end

   // record loads every cycle, qualified by complete
   always_ff @(posedge clk)
   begin
      wb.rob_ptr <= res_tag.rob_ptr;
      wb.prf_ptr <= res_tag.prf_ptr;
      wb.prf_val <= res_tag.prf_val;
      wb.data <= word;
   end

endmodule

`default_nettype wire

// ==== design/mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit
   import mul_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      go,
   input  mul_op_e                   op,
   input  logic [31:0]               src_a,
   input  logic [31:0]               src_b,
   input  logic [LG_ROB_ENTRIES-1:0] rob_ptr_in,
   input  logic [LG_PRF_ENTRIES-1:0] prf_ptr_in,
   input  logic                      has_dest,
   output logic                      complete,
   output mul_wb_t                   wb
);

   logic        req_valid;
   mul_req_t    req;
   logic        res_valid;
   logic [63:0] product;
   mul_tag_t    res_tag;

   mul_decode u_decode (
      .go         (go),
      .op         (op),
      .src_a      (src_a),
      .src_b      (src_b),
      .rob_ptr_in (rob_ptr_in),
      .prf_ptr_in (prf_ptr_in),
      .has_dest   (has_dest),
      .req_valid  (req_valid),
      .req        (req)
   );

   mul_execute u_execute (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .res_valid (res_valid),
      .product   (product),
      .res_tag   (res_tag)
   );

   mul_result u_result (
      .clk       (clk),
      .reset     (reset),
      .res_valid (res_valid),
      .product   (product),
      .res_tag   (res_tag),
      .complete  (complete),
      .wb        (wb)
   );

endmodule

`default_nettype wire
